//--- src.f
hw/audio_delay_pkg.sv
hw/delay_ram_if.sv
hw/delay_tap_if.sv
hw/delay_sequencer.sv
hw/delay_ram.sv
hw/delay_mixer.sv
hw/audio_delay.sv
verif/audio_delay_tb.sv

//--- verif/audio_delay_tb.sv
module audio_delay_tb import audio_delay_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int OUT_LATENCY  = 4; // edges from the accepting edge to sample_out_valid.
    localparam int MIN_SPACING  = 5;
    localparam int CYCLES_PER_SAMPLE = 12;
    localparam int WATCHDOG_SLACK    = 100;

    logic    clk;
    logic    rst;
    sample_t sample_in;
    logic    sample_in_valid;
    pot_t    pot_wet;
    pot_t    pot_rate;
    pot_t    pot_feedback;
    sample_t sample_out;
    logic    sample_out_valid;
    logic    ready;

    int cycle = 0;
    int last_accept = -100;
    int sent = 0;
    int value_errors = 0;
    int latency_errors = 0;
    int other_errors = 0;

    // every value written back into the line, oldest first.
    sample_t history [$];

    sample_t exp_value [$];
    int      exp_edge [$];

    audio_delay dut (
        .clk              (clk),
        .rst              (rst),
        .sample_in        (sample_in),
        .sample_in_valid  (sample_in_valid),
        .pot_wet          (pot_wet),
        .pot_rate         (pot_rate),
        .pot_feedback     (pot_feedback),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid),
        .ready            (ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic sample_t clamp16(input longint v);
        sample_t r;
        if (v > 32767) begin
            r = 16'sh7fff;
        end else if (v < -32768) begin
            r = 16'sh8000;
        end else begin
            r = sample_t'(v);
        end
        return r;
    endfunction

    function automatic int delay_of(input pot_t rate);
        return RATE_STEP * (1024 - int'(rate)) - 1;
    endfunction

    // expected output for one sample; w returns the value that goes back into the line.
    function automatic sample_t expected_output(input sample_t x, input sample_t d,
                                                input pot_t wet, input pot_t fb,
                                                output sample_t w);
        longint mix;
        longint echo;
        mix  = longint'(x) * (1024 - longint'(wet)) + longint'(d) * longint'(wet);
        echo = (longint'(d) * longint'(fb)) >>> GAIN_SHIFT;
        w    = clamp16(longint'(x) + echo);
        return clamp16(mix >>> GAIN_SHIFT);
    endfunction

    function automatic int random_gap();
        return $urandom_range(9, 6);
    endfunction

    task automatic check_sample(input sample_t got, input sample_t want, input int at_edge);
        if (got !== want) begin
            value_errors++;
            $display("** Error at %0t: sample_out %0d on edge %0d, expected %0d",
                     $time, got, at_edge, want);
        end
    endtask

    task automatic check_latency(input int got, input int want, input string what);
        if (got != want) begin
            latency_errors++;
            $display("** Error at %0t: %s took %0d edges, expected %0d",
                     $time, what, got, want);
        end
    endtask

    // drives one strobe and predicts whether the DUT takes it; the next strobe is gap cycles later.
    task automatic send_sample(input sample_t x, input pot_t rate, input pot_t wet,
                               input pot_t fb, input int gap);
        int      accept_edge;
        int      n;
        int      dly;
        sample_t d;
        sample_t w;
        sample_t y;
        @(negedge clk);
        sample_in       = x;
        pot_rate        = rate;
        pot_wet         = wet;
        pot_feedback    = fb;
        sample_in_valid = 1'b1;
        sent++;
        accept_edge = cycle + 1;
        if (ready === 1'b1 && accept_edge - last_accept >= MIN_SPACING) begin
            n   = history.size();
            dly = delay_of(rate);
            d   = (n >= dly) ? history[n - dly] : sample_t'(0); // older reads see the sweep.
            y   = expected_output(x, d, wet, fb, w);
            history.push_back(w);
            exp_value.push_back(y);
            exp_edge.push_back(accept_edge);
            last_accept = accept_edge;
        end
        @(negedge clk);
        sample_in_valid = 1'b0;
        // scramble the inputs so that only the latched values can be used.
        sample_in    = sample_t'($urandom);
        pot_rate     = pot_t'($urandom);
        pot_wet      = pot_t'($urandom);
        pot_feedback = pot_t'($urandom);
        repeat (gap - 2) @(negedge clk);
    endtask

    task automatic run_delay_test();
        pot_t rates [4];
        int   dly;
        rates = '{10'd0, 10'd1023, 10'd1020, 10'd1000};
        foreach (rates[i]) begin
            dly = delay_of(rates[i]);
            send_sample(sample_t'(12000), rates[i], 10'd1023, 10'd0, random_gap());
            for (int k = 0; k < dly + 2; k++) begin
                send_sample(sample_t'(0), rates[i], 10'd1023, 10'd0, random_gap());
            end
        end
    endtask

    task automatic run_mix_test();
        pot_t wet;
        for (int i = 0; i < 300; i++) begin
            wet = (i % 10 == 0) ? pot_t'(0) : pot_t'($urandom_range(1023, 0));
            send_sample(sample_t'($urandom), pot_t'($urandom_range(1023, 900)), wet,
                        10'd0, random_gap());
        end
    endtask

    task automatic run_feedback_test();
        sample_t x;
        for (int i = 0; i < 200; i++) begin
            if (i % 40 < 8) begin
                x = (i % 80 < 40) ? 16'sh7fff : 16'sh8000; // full-scale bursts.
            end else if (i % 40 < 12) begin
                x = sample_t'($urandom);
            end else begin
                x = '0;
            end
            send_sample(x, 10'd1020, pot_t'($urandom_range(1023, 512)),
                        pot_t'($urandom_range(1023, 900)), random_gap());
        end
    endtask

    task automatic run_early_test();
        for (int i = 0; i < 20; i++) begin
            send_sample(sample_t'($urandom), 10'd1010, 10'd700, 10'd300, $urandom_range(4, 2));
            send_sample(16'sh7fff, 10'd0, 10'd0, 10'd1023, 6); // must be dropped.
        end
    endtask

    // each output pulse is matched against the oldest accepted sample.
    always @(negedge clk) begin
        if (!rst && sample_out_valid === 1'b1) begin
            if (exp_value.size() == 0) begin
                other_errors++;
                $display("sample_out_valid pulsed at %0t while no accepted sample was waiting",
                         $time);
            end else begin
                check_latency(cycle - exp_edge[0], OUT_LATENCY, "sample_out_valid");
                check_sample(sample_out, exp_value[0], cycle);
                void'(exp_value.pop_front());
                void'(exp_edge.pop_front());
            end
        end
    end

    initial begin
        while (cycle <= DELAY_DEPTH + WATCHDOG_SLACK + CYCLES_PER_SAMPLE * sent) begin
            @(posedge clk);
        end
        $display("watchdog expired at %0t after %0d cycles and %0d strobes", $time, cycle, sent);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int release_cycle;
        int drain;
        void'($urandom(67269));
        rst             = 1'b1;
        sample_in       = '0;
        sample_in_valid = 1'b0;
        pot_wet         = '0;
        pot_rate        = '0;
        pot_feedback    = '0;

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        release_cycle = cycle;

        // strobes during the sweep are ignored by the DUT.
        do begin
            @(negedge clk);
            sample_in_valid = (ready !== 1'b1) && (cycle % 512 == 100);
            if (sample_in_valid) begin
                sent++;
            end
        end while (ready !== 1'b1);
        check_latency(cycle - release_cycle, DELAY_DEPTH, "ready after reset");

        run_delay_test();
        run_mix_test();
        run_feedback_test();
        run_early_test();

        drain = 0;
        while (exp_value.size() != 0 && drain < 20) begin
            @(negedge clk);
            drain++;
        end
        if (exp_value.size() != 0) begin
            other_errors += exp_value.size();
            $display("%0d accepted samples never produced sample_out_valid", exp_value.size());
        end

        $display("errors: %0d value, %0d latency, %0d other over %0d strobes",
                 value_errors, latency_errors, other_errors, sent);
        if (value_errors + latency_errors + other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- hw/audio_delay.sv
module audio_delay import audio_delay_pkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  sample_t sample_in,
    input  logic    sample_in_valid,

    input  pot_t    pot_wet,
    input  pot_t    pot_rate,
    input  pot_t    pot_feedback,

    output sample_t sample_out,
    output logic    sample_out_valid,

    output logic    ready
);

    delay_ram_if ram_bus ();
    delay_tap_if tap_bus ();

    // feedback path from the mixer back into the delay line.
    sample_t wb_data;
    logic    wb_valid;

    delay_sequencer u_sequencer (
        .clk             (clk),
        .rst             (rst),
        .sample_in       (sample_in),
        .sample_in_valid (sample_in_valid),
        .pot_wet         (pot_wet),
        .pot_rate        (pot_rate),
        .pot_feedback    (pot_feedback),
        .wb_data         (wb_data),
        .wb_valid        (wb_valid),
        .ready           (ready),
        .ram             (ram_bus.seq),
        .tap             (tap_bus.seq)
    );

    delay_ram u_ram (
        .clk  (clk),
        .port (ram_bus.ram)
    );

    delay_mixer u_mixer (
        .clk              (clk),
        .rst              (rst),
        .ram              (ram_bus.mix),
        .tap              (tap_bus.mix),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid),
        .wb_data          (wb_data),
        .wb_valid         (wb_valid)
    );

endmodule

//--- hw/delay_mixer.sv
module delay_mixer import audio_delay_pkg::*; (
    input  logic    clk,
    input  logic    rst,

    delay_ram_if.mix ram,
    delay_tap_if.mix tap,

    output sample_t sample_out,
    output logic    sample_out_valid,

    output sample_t wb_data,
    output logic    wb_valid
);

    // a gain is unsigned, one extra bit keeps it positive in signed products.
    localparam int COEF_W = $bits(gain_t) + 1;
    localparam int PROD_W = $bits(sample_t) + COEF_W;
    localparam int SUM_W  = PROD_W + 1;

    localparam int MIX_W = SUM_W - GAIN_SHIFT;
    localparam int FB_W  = PROD_W - GAIN_SHIFT;

    logic signed [COEF_W-1:0] wet_coef;
    logic signed [COEF_W-1:0] dry_coef;
    logic signed [COEF_W-1:0] fb_coef;

    logic signed [PROD_W-1:0] dry_term;
    logic signed [PROD_W-1:0] wet_term;
    logic signed [PROD_W-1:0] fb_term;

    logic signed [SUM_W-1:0] mix_sum;
    logic signed [MIX_W-1:0] mix_scaled;

    logic signed [FB_W-1:0]  fb_scaled;
    logic signed [MIX_W-1:0] fb_sum;

    sample_t delayed;

    function automatic sample_t sat16(input logic signed [MIX_W-1:0] v);
        sample_t result;
        if (v > SAMPLE_MAX) begin
            result = sample_t'(SAMPLE_MAX);
        end else if (v < SAMPLE_MIN) begin
            result = sample_t'(SAMPLE_MIN);
        end else begin
            result = sample_t'(v);
        end
        return result;
    endfunction

    assign delayed = ram.rd_data;

    assign wet_coef = $signed({1'b0, tap.wet_gain});
    assign dry_coef = $signed({1'b0, GAIN_UNITY - tap.wet_gain}); // 1024 - wet.
    assign fb_coef  = $signed({1'b0, tap.fb_gain});

    // each product fits exactly, the magnitude tops out at 2^25.
    assign dry_term = tap.dry * dry_coef;
    assign wet_term = delayed * wet_coef;
    assign fb_term  = delayed * fb_coef;

    assign mix_sum    = dry_term + wet_term;
    assign mix_scaled = MIX_W'(mix_sum >>> GAIN_SHIFT);

    // the echo is scaled first and then added to the dry sample.
    assign fb_scaled = FB_W'(fb_term >>> GAIN_SHIFT);
    assign fb_sum    = fb_scaled + tap.dry;

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_out_valid <= 1'b0;
            wb_valid         <= 1'b0;
        end else begin
            sample_out_valid <= tap.tap_valid;
            wb_valid         <= tap.tap_valid; // both strobes leave together.
        end
    end

    always_ff @(posedge clk) begin
        if (tap.tap_valid) begin
            sample_out <= sat16(mix_scaled);
            wb_data    <= sat16(fb_sum);
        end
    end

endmodule

//--- hw/delay_ram.sv
module delay_ram import audio_delay_pkg::*; (
    input logic clk,

    delay_ram_if.ram port
);

    sample_t mem [DELAY_DEPTH];

    addr_t rd_addr_q;

    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            mem[port.wr_addr] <= port.wr_data;
        end
    end

    // first stage holds the address, second stage the data.
    // the address only moves on a request, so rd_data stays put between reads.
    always_ff @(posedge clk) begin
        if (port.rd_en) begin
            rd_addr_q <= port.rd_addr;
        end
        port.rd_data <= mem[rd_addr_q];
    end

endmodule

//--- hw/delay_sequencer.sv
module delay_sequencer import audio_delay_pkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  sample_t sample_in,
    input  logic    sample_in_valid,

    input  pot_t    pot_wet,
    input  pot_t    pot_rate,
    input  pot_t    pot_feedback,

    input  sample_t wb_data,
    input  logic    wb_valid,

    output logic    ready,

    delay_ram_if.seq ram,
    delay_tap_if.seq tap
);

    typedef enum logic {
        SWEEP,
        RUN
    } state_t;

    // one stage for the read request, RAM_LATENCY stages in the ram, one for the tap.
    localparam int PIPE_LEN = RAM_LATENCY + 2;

    state_t state;

    addr_t wr_ptr;
    addr_t cur_ptr;
    addr_t pend_addr;
    addr_t sweep_addr;
    addr_t delay_len;

    logic sweep_we;
    logic accept;

    logic [PIPE_LEN-1:0] strobe_pipe;

    logic [$bits(pot_t):0]   rate_steps;
    logic [$bits(pot_t)+3:0] rate_span;

    // D = RATE_STEP * (1024 - pot_rate) - 1, which spans 3 to 4095.
    assign rate_steps = ($bits(pot_t) + 1)'(POT_SPAN) - {1'b0, pot_rate};
    assign rate_span  = ($bits(pot_t) + 4)'(rate_steps) * ($bits(pot_t) + 4)'(RATE_STEP);
    assign delay_len  = addr_t'(rate_span - ($bits(pot_t) + 4)'(1));

    // a strobe is dropped while a sample is still travelling towards the mixer.
    assign accept = sample_in_valid & ready & ~(|strobe_pipe);

    // a write-back on the accepting edge already counts for the new sample.
    assign cur_ptr = wb_valid ? wr_ptr + addr_t'(1) : wr_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= SWEEP;
            ready       <= 1'b0;
            wr_ptr      <= '0;
            sweep_we    <= 1'b0;
            strobe_pipe <= '0;
        end else begin
            strobe_pipe <= {strobe_pipe[PIPE_LEN-2:0], accept};

            case (state)
                SWEEP: begin
                    sweep_we <= 1'b1;
                    wr_ptr   <= wr_ptr + addr_t'(1); // wraps back to 0 at the end.
                    if (wr_ptr == addr_t'(DELAY_DEPTH - 1)) begin
                        state <= RUN;
                        ready <= 1'b1;
                    end
                end
                RUN: begin
                    sweep_we <= 1'b0;
                    wr_ptr   <= cur_ptr;
                end
                default: begin
                    state <= SWEEP;
                end
            endcase
        end
    end

    // sample, gains and addresses of the sample in flight.
    always_ff @(posedge clk) begin
        sweep_addr <= wr_ptr;
        if (accept) begin
            tap.dry      <= sample_in;
            tap.wet_gain <= gain_t'(pot_wet);
            tap.fb_gain  <= gain_t'(pot_feedback);
            pend_addr    <= cur_ptr;
            ram.rd_addr  <= cur_ptr - delay_len;
        end
    end

    assign ram.rd_en     = strobe_pipe[0];
    assign tap.tap_valid = strobe_pipe[PIPE_LEN-1];

    // the sweep and the write-back never overlap, so a plain mux is enough.
    assign ram.wr_en   = sweep_we | wb_valid;
    assign ram.wr_addr = sweep_we ? sweep_addr : pend_addr;
    assign ram.wr_data = sweep_we ? sample_t'(0) : wb_data;

endmodule

//--- hw/delay_tap_if.sv
interface delay_tap_if import audio_delay_pkg::*; ();

    sample_t dry;       // the input sample that goes with the current tap.
    gain_t   wet_gain;
    gain_t   fb_gain;
    logic    tap_valid; // high while rd_data belongs to dry.

    modport seq (
        output dry,
        output wet_gain,
        output fb_gain,
        output tap_valid
    );

    modport mix (
        input dry,
        input wet_gain,
        input fb_gain,
        input tap_valid
    );

endinterface

//--- hw/delay_ram_if.sv
interface delay_ram_if import audio_delay_pkg::*; ();

    // read port.
    addr_t   rd_addr;
    logic    rd_en;
    sample_t rd_data;

    // write port.
    addr_t   wr_addr;
    logic    wr_en;
    sample_t wr_data;

    modport seq (
        output rd_addr, rd_en,
        output wr_addr, wr_en, wr_data
    );

    modport ram (
        input  rd_addr, rd_en,
        input  wr_addr, wr_en, wr_data,
        output rd_data
    );

    // the mixer only sees the delayed sample.
    modport mix (
        input rd_data
    );

endinterface

//--- hw/audio_delay_pkg.sv
package audio_delay_pkg;

    // the delay line holds one second worth of samples at a low rate.
    localparam int DELAY_DEPTH = 4096;
    localparam int ADDR_W = $clog2(DELAY_DEPTH);

    localparam int RAM_LATENCY = 2; // address register plus output register.

    // gains are fixed point with 1024 meaning unity.
    localparam int GAIN_SHIFT = 10;

    localparam int RATE_STEP = 4; // samples of delay per pot step.

    typedef logic signed [15:0] sample_t;
    typedef logic [9:0] pot_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [GAIN_SHIFT:0] gain_t;

    // full scale of a pot plus one, so 1024 - pot never reaches zero.
    localparam int POT_SPAN = 1 << $bits(pot_t);

    localparam gain_t GAIN_UNITY = gain_t'(1 << GAIN_SHIFT);

    // limits of a signed 16-bit sample, used by the saturation.
    localparam int SAMPLE_MAX = 32767;
    localparam int SAMPLE_MIN = -32768;

endpackage
